/* common/control_pkg.sv */
`default_nettype none

package control_pkg;

  localparam int OPCODE_W = 6;
  localparam int FUNCT_W = 6;

  // FSM states, grouped by instruction class
  typedef enum logic [5:0] {
    RESET, RESET_INIT,
    FETCH, FETCH_WAIT, DECODE,
    ALU_RR, ALU_WRITE, SLT_RR, SLT_WRITE,
    ADD_IMM, IMM_WRITE,
    BEQ, BNE, BLE, BGT,
    LOAD, LOAD_WAIT, LOAD_END, STORE, STORE_WAIT,
    JUMP, JAL, JR,
    MULT, MULT_WAIT, MULT_END, DIV, DIV_WAIT, DIV_END,
    EXCEPTION, EXC_OVERFLOW, EXC_DIV_ZERO, EXC_OPCODE,
    EXCEPTION_WAIT, EXCEPTION_END
  } state_t;

  typedef enum logic [OPCODE_W-1:0] {
    OPCODE_R     = 6'h00,
    OPCODE_J     = 6'h02,
    OPCODE_JAL   = 6'h03,
    OPCODE_BEQ   = 6'h04,
    OPCODE_BNE   = 6'h05,
    OPCODE_BLE   = 6'h06,
    OPCODE_BGT   = 6'h07,
    OPCODE_ADDI  = 6'h08,
    OPCODE_ADDIU = 6'h09,
    OPCODE_LW    = 6'h23,
    OPCODE_SW    = 6'h2b
  } opcode_t;

  typedef enum logic [FUNCT_W-1:0] {
    FUNCT_JR   = 6'h08,
    FUNCT_MULT = 6'h18,
    FUNCT_DIV  = 6'h1a,
    FUNCT_ADD  = 6'h20,
    FUNCT_SUB  = 6'h22,
    FUNCT_AND  = 6'h24,
    FUNCT_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    LOAD_A = 3'b000,
    ADD    = 3'b001,
    SUB    = 3'b010,
    AND    = 3'b011,
    CMP    = 3'b111
  } alu_op_t;

  typedef enum logic [1:0] {SRCA_PC = 2'b00, SRCA_A = 2'b01} alu_srca_t;

  typedef enum logic [1:0] {
    SRCB_B         = 2'b00,
    SRCB_FOUR      = 2'b01,
    SRCB_IMM       = 2'b10,
    SRCB_IMM_SHIFT = 2'b11
  } alu_srcb_t;

  typedef enum logic [2:0] {
    PC_VECTOR     = 3'b000,
    PC_ALU_RESULT = 3'b001,
    PC_ALU_OUT    = 3'b011,
    PC_REG_A      = 3'b100,
    PC_JUMP       = 3'b101
  } pc_src_t;

  // Vector addresses select the handler byte for each cause
  typedef enum logic [2:0] {
    IORD_PC           = 3'b000,
    IORD_VEC_OVERFLOW = 3'b010,
    IORD_VEC_DIV_ZERO = 3'b011,
    IORD_VEC_OPCODE   = 3'b100,
    IORD_ALU_OUT      = 3'b101
  } iord_t;

  typedef enum logic [2:0] {
    DST_RT = 3'b000,
    DST_RD = 3'b001,
    DST_RA = 3'b010,
    DST_SP = 3'b100
  } reg_dst_t;

  typedef enum logic [3:0] {
    M2R_ALU_OUT = 4'b0000,
    M2R_MDR     = 4'b0001,
    M2R_PC      = 4'b0010,
    M2R_CMP     = 4'b0011,
    M2R_SP_TOP  = 4'b0110
  } mem_to_reg_t;

  typedef enum logic [1:0] {BR_LE = 2'b00, BR_GT = 2'b01, BR_EQ = 2'b10, BR_NE = 2'b11} branch_t;

  typedef enum logic [1:0] {NONE, OVERFLOW, DIV_ZERO, OPCODE} cause_t;

endpackage

`default_nettype wire

/* common/ctrl_word_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ctrl_word_if;
  import control_pkg::*;

  logic mult_ctrl;
  logic div_ctrl;
  logic ir_write;
  logic reg_write;
  logic write_mem;
  logic epc_write;
  logic pc_write;
  logic pc_write_cond;
  logic hi_ctrl;
  logic lo_ctrl;
  branch_t branch_type;
  alu_srca_t alu_srca;
  alu_srcb_t alu_srcb;
  alu_op_t alu_op;
  iord_t iord;
  pc_src_t pc_src;
  reg_dst_t reg_dst;
  mem_to_reg_t mem_to_reg;

  modport source (
    output mult_ctrl, div_ctrl, ir_write, reg_write, write_mem, epc_write, pc_write,
    output pc_write_cond, hi_ctrl, lo_ctrl, branch_type, alu_srca, alu_srcb, alu_op,
    output iord, pc_src, reg_dst, mem_to_reg
  );

  modport sink (
    input mult_ctrl, div_ctrl, ir_write, reg_write, write_mem, epc_write, pc_write,
    input pc_write_cond, hi_ctrl, lo_ctrl, branch_type, alu_srca, alu_srcb, alu_op,
    input iord, pc_src, reg_dst, mem_to_reg
  );

endinterface

`default_nettype wire

/* src/instruction_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instruction_decoder (
  input  logic [control_pkg::OPCODE_W-1:0] opcode,
  input  logic [control_pkg::FUNCT_W-1:0]  funct,
  output control_pkg::state_t              entry
);
  import control_pkg::*;

  always_comb begin
    entry = EXCEPTION;
    case (opcode)
      OPCODE_R: begin
        case (funct)
          FUNCT_ADD,
          FUNCT_AND,
          FUNCT_SUB: entry = ALU_RR;
          FUNCT_SLT: entry = SLT_RR;
          FUNCT_MULT: entry = MULT;
          FUNCT_DIV: entry = DIV;
          FUNCT_JR: entry = JR;
          default: entry = EXCEPTION;
        endcase
      end
      OPCODE_ADDI,
      OPCODE_ADDIU: entry = ADD_IMM;
      OPCODE_BEQ: entry = BEQ;
      OPCODE_BNE: entry = BNE;
      OPCODE_BLE: entry = BLE;
      OPCODE_BGT: entry = BGT;
      OPCODE_LW: entry = LOAD;
      OPCODE_SW: entry = STORE;
      OPCODE_J: entry = JUMP;
      OPCODE_JAL: entry = JAL;
      // Unknown opcode falls through to the illegal entry
      default: entry = EXCEPTION;
    endcase
  end

endmodule

`default_nettype wire

/* sequencer/fsm_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module fsm_sequencer #(
  parameter int FETCH_WAIT_CYCLES = 3
) (
  input  logic                clock,
  input  logic                reset,
  input  control_pkg::state_t entry,
  input  logic                overflow,
  input  logic                div_zero,
  input  logic                mult_end,
  input  logic                div_end,
  output control_pkg::state_t state
);
  import control_pkg::*;

  localparam int CNT_W = (FETCH_WAIT_CYCLES > 1) ? $clog2(FETCH_WAIT_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(FETCH_WAIT_CYCLES - 1);

  state_t next_state;
  cause_t cause;
  cause_t cause_in;
  logic [CNT_W-1:0] wait_count;
  logic exc_allowed;
  logic illegal;

  assign illegal = (state == DECODE) && (entry == EXCEPTION);

  // Reset and the exception path itself are not interruptible
  assign exc_allowed = !(state inside {RESET, RESET_INIT, EXCEPTION, EXC_OVERFLOW,
                                       EXC_DIV_ZERO, EXC_OPCODE, EXCEPTION_WAIT,
                                       EXCEPTION_END});

  // Opcode beats div_zero beats overflow
  always_comb begin
    if (illegal) begin
      cause_in = OPCODE;
    end else if (div_zero) begin
      cause_in = DIV_ZERO;
    end else begin
      cause_in = OVERFLOW;
    end
  end

  always_comb begin
    next_state = FETCH;
    case (state)
      RESET: next_state = RESET_INIT;
      RESET_INIT: next_state = FETCH;
      FETCH: next_state = FETCH_WAIT;
      FETCH_WAIT: next_state = (wait_count == LAST_WAIT) ? DECODE : FETCH_WAIT;
      DECODE: next_state = entry;
      ALU_RR: next_state = ALU_WRITE;
      SLT_RR: next_state = SLT_WRITE;
      ADD_IMM: next_state = IMM_WRITE;
      LOAD: next_state = LOAD_WAIT;
      LOAD_WAIT: next_state = LOAD_END;
      STORE: next_state = STORE_WAIT;
      MULT: next_state = MULT_WAIT;
      MULT_WAIT: next_state = mult_end ? MULT_END : MULT_WAIT;
      DIV: next_state = DIV_WAIT;
      DIV_WAIT: next_state = div_end ? DIV_END : DIV_WAIT;
      EXCEPTION: begin
        case (cause)
          OVERFLOW: next_state = EXC_OVERFLOW;
          DIV_ZERO: next_state = EXC_DIV_ZERO;
          default: next_state = EXC_OPCODE;
        endcase
      end
      EXC_OVERFLOW,
      EXC_DIV_ZERO,
      EXC_OPCODE: next_state = EXCEPTION_WAIT;
      EXCEPTION_WAIT: next_state = EXCEPTION_END;
      // Single-cycle tails return to fetch
      default: next_state = FETCH;
    endcase
    if (exc_allowed && (overflow || div_zero)) begin
      next_state = EXCEPTION;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= RESET;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || state != FETCH_WAIT) begin
      wait_count <= '0;
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cause <= NONE;
    end else if (next_state == EXCEPTION) begin
      cause <= cause_in;
    end else if (state == EXCEPTION_END) begin
      cause <= NONE;
    end
  end

endmodule

`default_nettype wire

/* src/control_word_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module control_word_encoder (
  input control_pkg::state_t state,
  ctrl_word_if.source        cw
);
  import control_pkg::*;

  always_comb begin
    cw.mult_ctrl = 1'b0;
    cw.div_ctrl = 1'b0;
    cw.ir_write = 1'b0;
    cw.reg_write = 1'b0;
    cw.write_mem = 1'b0;
    cw.epc_write = 1'b0;
    cw.pc_write = 1'b0;
    cw.pc_write_cond = 1'b0;
    cw.hi_ctrl = 1'b0;
    cw.lo_ctrl = 1'b0;
    cw.branch_type = BR_LE;
    cw.alu_srca = SRCA_PC;
    cw.alu_srcb = SRCB_B;
    cw.alu_op = LOAD_A;
    cw.iord = IORD_PC;
    cw.pc_src = PC_VECTOR;
    cw.reg_dst = DST_RT;
    cw.mem_to_reg = M2R_ALU_OUT;

    case (state)
      RESET_INIT: begin
        cw.reg_write = 1'b1;
        cw.reg_dst = DST_SP;
        cw.mem_to_reg = M2R_SP_TOP;
      end
      FETCH: begin
        cw.ir_write = 1'b1;
        cw.pc_write = 1'b1;
        cw.alu_srcb = SRCB_FOUR;
        cw.alu_op = ADD;
        cw.pc_src = PC_ALU_RESULT;
      end
      // Branch target lands in ALU out
      DECODE: begin
        cw.alu_srcb = SRCB_IMM_SHIFT;
        cw.alu_op = ADD;
      end
      // ALU control in the datapath refines add, and, sub from funct
      ALU_RR: begin
        cw.alu_srca = SRCA_A;
        cw.alu_op = ADD;
      end
      SLT_RR: begin
        cw.alu_srca = SRCA_A;
        cw.alu_op = CMP;
      end
      ALU_WRITE,
      SLT_WRITE: begin
        cw.reg_write = 1'b1;
        cw.reg_dst = DST_RD;
        cw.mem_to_reg = (state == SLT_WRITE) ? M2R_CMP : M2R_ALU_OUT;
      end
      ADD_IMM: begin
        cw.alu_srca = SRCA_A;
        cw.alu_srcb = SRCB_IMM;
        cw.alu_op = ADD;
      end
      IMM_WRITE: cw.reg_write = 1'b1;
      BEQ,
      BNE,
      BLE,
      BGT: begin
        cw.pc_write_cond = 1'b1;
        cw.alu_srca = SRCA_A;
        cw.pc_src = PC_ALU_OUT;
        cw.alu_op = (state inside {BEQ, BNE}) ? SUB : CMP;
        case (state)
          BEQ: cw.branch_type = BR_EQ;
          BNE: cw.branch_type = BR_NE;
          BGT: cw.branch_type = BR_GT;
          default: cw.branch_type = BR_LE;
        endcase
      end
      // Address is base plus offset, ready in ALU out for the next cycle
      LOAD,
      STORE: begin
        cw.iord = IORD_ALU_OUT;
        cw.alu_srca = SRCA_A;
        cw.alu_srcb = SRCB_IMM;
        cw.alu_op = ADD;
      end
      LOAD_WAIT: cw.iord = IORD_ALU_OUT;
      LOAD_END: begin
        cw.iord = IORD_ALU_OUT;
        cw.reg_write = 1'b1;
        cw.mem_to_reg = M2R_MDR;
      end
      STORE_WAIT: begin
        cw.iord = IORD_ALU_OUT;
        cw.write_mem = 1'b1;
      end
      JUMP: begin
        cw.pc_write = 1'b1;
        cw.pc_src = PC_JUMP;
      end
      JAL: begin
        cw.pc_write = 1'b1;
        cw.pc_src = PC_JUMP;
        cw.reg_write = 1'b1;
        cw.reg_dst = DST_RA;
        cw.mem_to_reg = M2R_PC;
      end
      JR: begin
        cw.pc_write = 1'b1;
        cw.pc_src = PC_REG_A;
      end
      MULT,
      MULT_WAIT: cw.mult_ctrl = 1'b1;
      DIV,
      DIV_WAIT: cw.div_ctrl = 1'b1;
      MULT_END,
      DIV_END: begin
        cw.hi_ctrl = 1'b1;
        cw.lo_ctrl = 1'b1;
      end
      // EPC gets PC - 4, the faulting instruction
      EXCEPTION: begin
        cw.epc_write = 1'b1;
        cw.alu_srcb = SRCB_FOUR;
        cw.alu_op = SUB;
      end
      EXC_OVERFLOW: cw.iord = IORD_VEC_OVERFLOW;
      EXC_DIV_ZERO: cw.iord = IORD_VEC_DIV_ZERO;
      EXC_OPCODE: cw.iord = IORD_VEC_OPCODE;
      EXCEPTION_END: cw.pc_write = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/mips_control.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_control #(
  parameter int FETCH_WAIT_CYCLES = 3
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [control_pkg::OPCODE_W-1:0]              opcode,
  input  logic [control_pkg::FUNCT_W-1:0]               funct,
  input  logic                                          overflow,
  input  logic                                          div_zero,
  input  logic                                          mult_end,
  input  logic                                          div_end,
  output logic [$bits(control_pkg::state_t)-1:0]        state,
  output logic                                          mult_ctrl,
  output logic                                          div_ctrl,
  output logic                                          ir_write,
  output logic                                          reg_write,
  output logic                                          write_mem,
  output logic                                          epc_write,
  output logic                                          pc_write,
  output logic                                          pc_write_cond,
  output logic                                          hi_ctrl,
  output logic                                          lo_ctrl,
  output logic [$bits(control_pkg::branch_t)-1:0]       branch_type,
  output logic [$bits(control_pkg::alu_srca_t)-1:0]     alu_srca,
  output logic [$bits(control_pkg::alu_srcb_t)-1:0]     alu_srcb,
  output logic [$bits(control_pkg::alu_op_t)-1:0]       alu_op,
  output logic [$bits(control_pkg::iord_t)-1:0]         iord,
  output logic [$bits(control_pkg::pc_src_t)-1:0]       pc_src,
  output logic [$bits(control_pkg::reg_dst_t)-1:0]      reg_dst,
  output logic [$bits(control_pkg::mem_to_reg_t)-1:0]   mem_to_reg
);
  import control_pkg::*;

  state_t entry;
  state_t fsm_state;

  ctrl_word_if cw ();

  instruction_decoder u_decoder (
    .opcode (opcode),
    .funct  (funct),
    .entry  (entry)
  );

  fsm_sequencer #(
    .FETCH_WAIT_CYCLES (FETCH_WAIT_CYCLES)
  ) u_sequencer (
    .clock    (clock),
    .reset    (reset),
    .entry    (entry),
    .overflow (overflow),
    .div_zero (div_zero),
    .mult_end (mult_end),
    .div_end  (div_end),
    .state    (fsm_state)
  );

  control_word_encoder u_encoder (
    .state (fsm_state),
    .cw    (cw)
  );

  assign state = fsm_state;
  assign mult_ctrl = cw.mult_ctrl;
  assign div_ctrl = cw.div_ctrl;
  assign ir_write = cw.ir_write;
  assign reg_write = cw.reg_write;
  assign write_mem = cw.write_mem;
  assign epc_write = cw.epc_write;
  assign pc_write = cw.pc_write;
  assign pc_write_cond = cw.pc_write_cond;
  assign hi_ctrl = cw.hi_ctrl;
  assign lo_ctrl = cw.lo_ctrl;
  assign branch_type = cw.branch_type;
  assign alu_srca = cw.alu_srca;
  assign alu_srcb = cw.alu_srcb;
  assign alu_op = cw.alu_op;
  assign iord = cw.iord;
  assign pc_src = cw.pc_src;
  assign reg_dst = cw.reg_dst;
  assign mem_to_reg = cw.mem_to_reg;

endmodule

`default_nettype wire

/* verification/mips_control_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_control_asserts (
  input logic                                   clock,
  input logic                                   reset,
  input logic [$bits(control_pkg::state_t)-1:0] state,
  input logic                                   mult_ctrl,
  input logic                                   div_ctrl,
  input logic                                   pc_write,
  input logic                                   pc_write_cond
);
  import control_pkg::*;

  mult_div_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(mult_ctrl && div_ctrl))
    else $error("mult_ctrl and div_ctrl high together");

  pc_write_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(pc_write && pc_write_cond))
    else $error("pc_write and pc_write_cond high together");

  // Cause dispatch right after EXCEPTION
  exception_dispatch: assert property (@(posedge clock) disable iff (reset)
    (state == EXCEPTION) |=> (state inside {EXC_OVERFLOW, EXC_DIV_ZERO, EXC_OPCODE}))
    else $error("EXCEPTION not followed by a cause state");

endmodule

bind mips_control mips_control_asserts u_asserts (
  .clock         (clock),
  .reset         (reset),
  .state         (state),
  .mult_ctrl     (mult_ctrl),
  .div_ctrl      (div_ctrl),
  .pc_write      (pc_write),
  .pc_write_cond (pc_write_cond)
);

`default_nettype wire

/* verification/mips_control_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_control_tb;
  import control_pkg::*;

  localparam int FETCH_WAIT_CYCLES = 4;
  localparam int NUM_INSTRUCTIONS = 400;
  localparam int CYCLE_LIMIT = 64;

  logic clock = 1'b0;
  logic reset;
  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT_W-1:0] funct;
  logic overflow;
  logic div_zero;
  logic mult_end;
  logic div_end;

  logic [5:0] state;
  logic mult_ctrl, div_ctrl, ir_write, reg_write, write_mem, epc_write;
  logic pc_write, pc_write_cond, hi_ctrl, lo_ctrl;
  logic [1:0] branch_type, alu_srca, alu_srcb;
  logic [2:0] alu_op, iord, pc_src, reg_dst;
  logic [3:0] mem_to_reg;

  // Reference model state
  state_t exp_state;
  cause_t exp_cause;
  int fetch_count;
  int end_delay;

  logic exp_mult_ctrl, exp_div_ctrl, exp_ir_write, exp_reg_write, exp_write_mem;
  logic exp_epc_write, exp_pc_write, exp_pc_write_cond, exp_hi_ctrl, exp_lo_ctrl;
  branch_t exp_branch_type;
  alu_srca_t exp_alu_srca;
  alu_srcb_t exp_alu_srcb;
  alu_op_t exp_alu_op;
  iord_t exp_iord;
  pc_src_t exp_pc_src;
  reg_dst_t exp_reg_dst;
  mem_to_reg_t exp_mem_to_reg;

  int mismatches = 0;
  int timeouts = 0;
  int done_count = 0;
  logic [31:0] lfsr = 32'h92d8;

  // {opcode, funct} of every kept instruction
  logic [11:0] legal_codes [17] = '{
    {6'h00, 6'h20}, {6'h00, 6'h24}, {6'h00, 6'h22}, {6'h00, 6'h2a}, {6'h00, 6'h08},
    {6'h00, 6'h18}, {6'h00, 6'h1a}, {6'h08, 6'h00}, {6'h09, 6'h00}, {6'h04, 6'h00},
    {6'h05, 6'h00}, {6'h06, 6'h00}, {6'h07, 6'h00}, {6'h23, 6'h00}, {6'h2b, 6'h00},
    {6'h02, 6'h00}, {6'h03, 6'h00}
  };

  mips_control #(.FETCH_WAIT_CYCLES(FETCH_WAIT_CYCLES)) DUT (.*);

  always #10 clock = ~clock;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic state_t decode_entry(input logic [5:0] op, input logic [5:0] fn);
    state_t s;
    s = EXCEPTION;
    case (op)
      6'h00: begin
        case (fn)
          6'h20, 6'h22, 6'h24: s = ALU_RR;
          6'h2a: s = SLT_RR;
          6'h18: s = MULT;
          6'h1a: s = DIV;
          6'h08: s = JR;
          default: s = EXCEPTION;
        endcase
      end
      6'h08, 6'h09: s = ADD_IMM;
      6'h04: s = BEQ;
      6'h05: s = BNE;
      6'h06: s = BLE;
      6'h07: s = BGT;
      6'h23: s = LOAD;
      6'h2b: s = STORE;
      6'h02: s = JUMP;
      6'h03: s = JAL;
      default: s = EXCEPTION;
    endcase
    return s;
  endfunction

  task automatic set_expected(input state_t s);
    {exp_mult_ctrl, exp_div_ctrl, exp_ir_write, exp_reg_write, exp_write_mem} = '0;
    {exp_epc_write, exp_pc_write, exp_pc_write_cond, exp_hi_ctrl, exp_lo_ctrl} = '0;
    exp_branch_type = BR_LE;
    exp_alu_srca = SRCA_PC;
    exp_alu_srcb = SRCB_B;
    exp_alu_op = LOAD_A;
    exp_iord = IORD_PC;
    exp_pc_src = PC_VECTOR;
    exp_reg_dst = DST_RT;
    exp_mem_to_reg = M2R_ALU_OUT;
    if (s inside {ALU_RR, SLT_RR, ADD_IMM, BEQ, BNE, BLE, BGT, LOAD, STORE}) begin
      exp_alu_srca = SRCA_A;
    end
    if (s inside {FETCH, DECODE, ALU_RR, ADD_IMM, LOAD, STORE}) begin
      exp_alu_op = ADD;
    end
    if (s inside {ADD_IMM, LOAD, STORE}) begin
      exp_alu_srcb = SRCB_IMM;
    end
    if (s inside {LOAD, LOAD_WAIT, LOAD_END, STORE, STORE_WAIT}) begin
      exp_iord = IORD_ALU_OUT;
    end
    exp_reg_write = s inside {RESET_INIT, ALU_WRITE, SLT_WRITE, IMM_WRITE, LOAD_END, JAL};
    exp_pc_write = s inside {FETCH, JUMP, JAL, JR, EXCEPTION_END};
    exp_mult_ctrl = s inside {MULT, MULT_WAIT};
    exp_div_ctrl = s inside {DIV, DIV_WAIT};
    exp_hi_ctrl = s inside {MULT_END, DIV_END};
    exp_lo_ctrl = exp_hi_ctrl;
    case (s)
      RESET_INIT: begin
        exp_reg_dst = DST_SP;
        exp_mem_to_reg = M2R_SP_TOP;
      end
      FETCH: begin
        exp_ir_write = 1'b1;
        exp_alu_srcb = SRCB_FOUR;
        exp_pc_src = PC_ALU_RESULT;
      end
      DECODE: exp_alu_srcb = SRCB_IMM_SHIFT;
      SLT_RR: exp_alu_op = CMP;
      ALU_WRITE: exp_reg_dst = DST_RD;
      SLT_WRITE: begin
        exp_reg_dst = DST_RD;
        exp_mem_to_reg = M2R_CMP;
      end
      BEQ, BNE, BLE, BGT: begin
        exp_pc_write_cond = 1'b1;
        exp_pc_src = PC_ALU_OUT;
        exp_alu_op = (s == BEQ || s == BNE) ? SUB : CMP;
        exp_branch_type = (s == BEQ) ? BR_EQ : (s == BNE) ? BR_NE : (s == BGT) ? BR_GT : BR_LE;
      end
      LOAD_END: exp_mem_to_reg = M2R_MDR;
      STORE_WAIT: exp_write_mem = 1'b1;
      JUMP: exp_pc_src = PC_JUMP;
      JAL: begin
        exp_pc_src = PC_JUMP;
        exp_reg_dst = DST_RA;
        exp_mem_to_reg = M2R_PC;
      end
      JR: exp_pc_src = PC_REG_A;
      EXCEPTION: begin
        exp_epc_write = 1'b1;
        exp_alu_srcb = SRCB_FOUR;
        exp_alu_op = SUB;
      end
      EXC_OVERFLOW: exp_iord = IORD_VEC_OVERFLOW;
      EXC_DIV_ZERO: exp_iord = IORD_VEC_DIV_ZERO;
      EXC_OPCODE: exp_iord = IORD_VEC_OPCODE;
      default: begin
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  task automatic compare_outputs;
    check_value("state", state, exp_state);
    check_value("mult_ctrl", mult_ctrl, exp_mult_ctrl);
    check_value("div_ctrl", div_ctrl, exp_div_ctrl);
    check_value("ir_write", ir_write, exp_ir_write);
    check_value("reg_write", reg_write, exp_reg_write);
    check_value("write_mem", write_mem, exp_write_mem);
    check_value("epc_write", epc_write, exp_epc_write);
    check_value("pc_write", pc_write, exp_pc_write);
    check_value("pc_write_cond", pc_write_cond, exp_pc_write_cond);
    check_value("hi_ctrl", hi_ctrl, exp_hi_ctrl);
    check_value("lo_ctrl", lo_ctrl, exp_lo_ctrl);
    check_value("branch_type", branch_type, exp_branch_type);
    check_value("alu_srca", alu_srca, exp_alu_srca);
    check_value("alu_srcb", alu_srcb, exp_alu_srcb);
    check_value("alu_op", alu_op, exp_alu_op);
    check_value("iord", iord, exp_iord);
    check_value("pc_src", pc_src, exp_pc_src);
    check_value("reg_dst", reg_dst, exp_reg_dst);
    check_value("mem_to_reg", mem_to_reg, exp_mem_to_reg);
  endtask

  // Advances the model by the rising edge that just passed
  task automatic update_model;
    state_t nxt;
    state_t ent;
    ent = decode_entry(opcode, funct);
    nxt = FETCH;
    case (exp_state)
      RESET: nxt = RESET_INIT;
      FETCH: nxt = FETCH_WAIT;
      FETCH_WAIT: nxt = (fetch_count == FETCH_WAIT_CYCLES) ? DECODE : FETCH_WAIT;
      DECODE: nxt = ent;
      ALU_RR: nxt = ALU_WRITE;
      SLT_RR: nxt = SLT_WRITE;
      ADD_IMM: nxt = IMM_WRITE;
      LOAD: nxt = LOAD_WAIT;
      LOAD_WAIT: nxt = LOAD_END;
      STORE: nxt = STORE_WAIT;
      MULT: nxt = MULT_WAIT;
      MULT_WAIT: nxt = mult_end ? MULT_END : MULT_WAIT;
      DIV: nxt = DIV_WAIT;
      DIV_WAIT: nxt = div_end ? DIV_END : DIV_WAIT;
      EXCEPTION: begin
        nxt = (exp_cause == OVERFLOW) ? EXC_OVERFLOW :
              (exp_cause == DIV_ZERO) ? EXC_DIV_ZERO : EXC_OPCODE;
      end
      EXC_OVERFLOW, EXC_DIV_ZERO, EXC_OPCODE: nxt = EXCEPTION_WAIT;
      EXCEPTION_WAIT: nxt = EXCEPTION_END;
      default: nxt = FETCH;
    endcase
    if (!(exp_state inside {RESET, RESET_INIT, EXCEPTION, EXC_OVERFLOW, EXC_DIV_ZERO,
                            EXC_OPCODE, EXCEPTION_WAIT, EXCEPTION_END})
        && (overflow || div_zero)) begin
      nxt = EXCEPTION;
    end
    if (nxt == EXCEPTION) begin
      exp_cause = (exp_state == DECODE && ent == EXCEPTION) ? OPCODE :
                  div_zero ? DIV_ZERO : OVERFLOW;
    end else if (exp_state == EXCEPTION_END) begin
      exp_cause = NONE;
    end
    fetch_count = (nxt != FETCH_WAIT) ? 0 : (exp_state == FETCH_WAIT) ? fetch_count + 1 : 1;
    exp_state = nxt;
    if (reset) begin
      exp_state = RESET;
      exp_cause = NONE;
      fetch_count = 0;
    end
  endtask

  // Inputs chosen here are sampled with the DUT still in exp_state
  task automatic drive_inputs;
    int idx;
    // Stray end strobes outside the matching wait must be ignored
    mult_end = (take_bits(2) == 0);
    div_end = (take_bits(2) == 0);
    if (exp_state == FETCH) begin
      if (take_bits(3) == 0) begin
        opcode = 6'(take_bits(6));
        funct = 6'(take_bits(6));
      end else begin
        idx = int'(take_bits(5)) % 17;
        {opcode, funct} = legal_codes[idx];
        if (opcode != 6'h00) begin
          funct = 6'(take_bits(6));
        end
      end
    end
    if (exp_state == MULT || exp_state == DIV) begin
      end_delay = int'(take_bits(4));
    end
    if (exp_state == MULT_WAIT) begin
      mult_end = (end_delay == 0);
    end else if (exp_state == DIV_WAIT) begin
      div_end = (end_delay == 0);
    end
    if ((exp_state == MULT_WAIT || exp_state == DIV_WAIT) && end_delay > 0) begin
      end_delay--;
    end
    if (exp_state == ALU_RR || exp_state == ADD_IMM) begin
      overflow = (take_bits(2) == 0);
    end else begin
      overflow = (take_bits(7) == 0);
    end
    if (exp_state == DIV_WAIT) begin
      div_zero = (take_bits(3) == 0);
    end else begin
      div_zero = (take_bits(7) == 0);
    end
  endtask

  task automatic step_cycle;
    @(negedge clock);
    update_model();
    set_expected(exp_state);
    compare_outputs();
    drive_inputs();
  endtask

  task automatic wait_for_fetch;
    int cycles;
    cycles = 0;
    while (state !== FETCH && cycles < CYCLE_LIMIT) begin
      step_cycle();
      cycles++;
    end
    if (state !== FETCH) begin
      $display("ERROR at %0d ns: FETCH not reached after reset within %0d cycles",
               $time, CYCLE_LIMIT);
      timeouts++;
    end
  endtask

  task automatic run_instruction;
    int cycles;
    cycles = 0;
    do begin
      step_cycle();
      cycles++;
    end while (state !== FETCH && cycles < CYCLE_LIMIT);
    if (state !== FETCH) begin
      $display("ERROR at %0d ns: instruction did not return to FETCH within %0d cycles",
               $time, CYCLE_LIMIT);
      timeouts++;
    end else begin
      done_count++;
    end
  endtask

  initial begin : main
    int n;
    reset = 1'b1;
    opcode = '0;
    funct = '0;
    overflow = 1'b0;
    div_zero = 1'b0;
    mult_end = 1'b0;
    div_end = 1'b0;
    exp_state = RESET;
    exp_cause = NONE;
    fetch_count = 0;
    end_delay = 0;
    repeat (5) step_cycle();
    reset = 1'b0;
    wait_for_fetch();
    for (n = 0; n < NUM_INSTRUCTIONS && timeouts == 0; n++) begin
      run_instruction();
    end
    $display("Summary: %0d instructions, %0d mismatches, %0d timeouts",
             done_count, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
common/control_pkg.sv
common/ctrl_word_if.sv
src/instruction_decoder.sv
sequencer/fsm_sequencer.sv
src/control_word_encoder.sv
src/mips_control.sv
verification/mips_control_asserts.sv
verification/mips_control_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module mips_control_tb
./obj_dir/Vmips_control_tb > sim.log 2>&1
cat sim.log

if grep -qx "Finished with errors" sim.log; then
  exit 1
fi
